//--- verilog.f
+incdir+src
src/althea_pkg.sv
src/bus_sampler.sv
src/bus_protocol.sv
src/gearbox_ram.sv
src/playback_sequencer.sv
src/althea_top.sv
bench/tb_althea_assert.sv
bench/tb_althea.sv

//--- run.sh
#!/bin/sh
# build the althea testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal --top-module tb_althea \
	-f verilog.f --Mdir obj_dir -o tb_althea; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/tb_althea +verilator+error+limit+100)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** TEST PASSED ***'; then
	exit 0
fi
exit 1

//--- bench/tb_althea.sv
// testbench for the althea register core
// runs host bus transactions through the top level and checks read-back,
// error counting and the playback byte stream
`timescale 1ns/1ps

`include "althea_consts.svh"

module tb_althea
	import althea_pkg::*;
();
	localparam int phase_cycles = 12;     // enable high and low time per beat
	localparam int cycle_limit  = 6000;   // roughly twice the whole run
	localparam int model_words  = `PLAYBACK_END / `DATA_BEATS;

	logic         clock;
	logic         reset125;
	logic         enable;
	logic         read;
	logic         register_select;
	bus_byte_t    bus_in;
	bus_byte_t    bus_out;
	logic         bus_drive;
	logic         ack_valid;
	error_count_t error_count;
	bus_byte_t    playback_byte;
	logic         playback_sync;

	data_word_t model_mem [model_words];   // what the host wrote
	int seed;
	int errors;
	int checks;
	int cycle_count;

	althea_top DUT (
		.clock(clock), .reset125(reset125),
		.enable(enable), .read(read), .register_select(register_select), .bus_in(bus_in),
		.bus_out(bus_out), .bus_drive(bus_drive), .ack_valid(ack_valid),
		.error_count(error_count), .playback_byte(playback_byte),
		.playback_sync(playback_sync)
	);

	always #10 clock = ~clock;

	// ------------------------------
	// helpers

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		checks++;
		assert (got === expected) else begin
			$display("Error at %0d ns: %s is %0h, expected %0h", $time, name, got, expected);
			errors++;
		end
	endtask

	// one beat with levels first, then an enable pulse and the gap
	task automatic host_beat(input logic rd, input logic sel, input bus_byte_t data,
			output bus_byte_t captured);
		logic acked;
		acked = 1'b0;
		captured = '0;
		@(negedge clock);
		read = rd;
		register_select = sel;
		bus_in = data;
		@(negedge clock);
		enable = 1'b1;
		repeat (phase_cycles) begin
			@(negedge clock);
			if (ack_valid && !acked) begin
				acked = 1'b1;
				captured = bus_out;   // read byte is settled once ack shows
			end
		end
		enable = 1'b0;
		repeat (phase_cycles) @(negedge clock);
		assert (acked) else begin
			$display("No ack_valid seen during the beat ending at %0d ns", $time);
			errors++;
		end
		check_value("bus_drive", bus_drive, rd);
	endtask

	task automatic write_address(input word_addr_t addr);
		logic [`ADDR_BEATS*`BUS_WIDTH-1:0] addr_bytes;
		bus_byte_t unused;
		addr_bytes = '0;
		addr_bytes[`ADDR_DEPTH-1:0] = addr;
		for (int i = `ADDR_BEATS - 1; i >= 0; i--) begin
			host_beat(1'b0, 1'b0, addr_bytes[i*`BUS_WIDTH +: `BUS_WIDTH], unused);
		end
	endtask

	task automatic write_data(input data_word_t word);
		bus_byte_t unused;
		for (int i = `DATA_BEATS - 1; i >= 0; i--) begin
			host_beat(1'b0, 1'b1, word[i*`BUS_WIDTH +: `BUS_WIDTH], unused);
		end
	endtask

	task automatic read_data(output data_word_t word);
		bus_byte_t lane_byte;
		word = '0;
		for (int i = `DATA_BEATS - 1; i >= 0; i--) begin
			host_beat(1'b1, 1'b1, '0, lane_byte);
			word[i*`BUS_WIDTH +: `BUS_WIDTH] = lane_byte;   // msb arrives first
		end
	endtask

	// byte k lives in word k/4 and lane 0 is its low byte
	function automatic bus_byte_t playback_expected(input int k);
		return model_mem[k / `DATA_BEATS][(k % `DATA_BEATS)*`BUS_WIDTH +: `BUS_WIDTH];
	endfunction

	task automatic report_test(input int number, input string name, input int errors_before);
		if (errors == errors_before) $display("test %0d %s: ok", number, name);
		else $display("test %0d %s: %0d errors", number, name, errors - errors_before);
	endtask

	// ------------------------------
	// tests

	initial begin
		data_word_t got;
		error_count_t count_before;
		int mark;
		int k;
		int assert_failures;
		logic sync_found;
		clock = 1'b0;
		reset125 = 1'b1;
		enable = 1'b0;
		read = 1'b0;
		register_select = 1'b0;
		bus_in = '0;
		seed = 3377;
		errors = 0;
		checks = 0;
		repeat (4) @(negedge clock);
		reset125 = 1'b0;

		mark = errors;
		@(negedge clock);
		check_value("ack_valid", ack_valid, 0);
		check_value("playback_sync", playback_sync, 0);
		check_value("bus_out", bus_out, 0);
		check_value("error_count", error_count, 0);
		report_test(1, "after reset", mark);

		mark = errors;
		for (int i = 0; i < 4; i++) model_mem[i] = $random(seed);
		write_address('0);
		for (int i = 0; i < 4; i++) write_data(model_mem[i]);
		write_address('0);
		for (int i = 0; i < 4; i++) begin
			read_data(got);
			check_value("bus_out word", got, model_mem[i]);
		end
		report_test(2, "write and read back", mark);

		mark = errors;
		write_address(word_addr_t'(2));
		read_data(got);
		check_value("bus_out word", got, model_mem[2]);
		report_test(3, "address load", mark);

		mark = errors;
		count_before = error_count;
		host_beat(1'b0, 1'b1, 8'ha5, got[7:0]);   // half a data word
		host_beat(1'b0, 1'b1, 8'h5a, got[7:0]);
		write_address(word_addr_t'(4));
		check_value("error_count", error_count, count_before + 1'b1);
		for (int i = 4; i < model_words; i++) begin
			model_mem[i] = $random(seed);
			write_data(model_mem[i]);
		end
		write_address(word_addr_t'(4));
		read_data(got);
		check_value("bus_out word", got, model_mem[4]);
		report_test(4, "error counting", mark);

		mark = errors;
		sync_found = 1'b0;
		for (int n = 0; n < 2 * `PLAYBACK_END && !sync_found; n++) begin
			@(negedge clock);
			sync_found = playback_sync;
		end
		assert (sync_found) else begin
			$display("playback_sync never came high at %0d ns", $time);
			errors++;
		end
		if (sync_found) begin
			// sync lands while byte SYNC_DELAY-1 is out
			for (int i = 0; i < `PLAYBACK_END; i++) begin
				k = (`SYNC_DELAY - 1 + i) % `PLAYBACK_END;
				check_value("playback_byte", playback_byte, playback_expected(k));
				@(negedge clock);
			end
		end
		report_test(5, "playback", mark);

		assert_failures = DUT.u_assert.ack_failures + DUT.u_assert.sync_width_failures
			+ DUT.u_assert.sync_gap_failures;
		$display("checks %0d, errors %0d, assertion failures %0d",
			checks, errors, assert_failures);
		if (errors == 0 && assert_failures == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// watchdog
	initial begin
		cycle_count = 0;
		while (cycle_count < cycle_limit) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- bench/tb_althea_assert.sv
// protocol and playback assertions for the althea top level
// ack must go quiet after enable drops, sync pulses are single and evenly spaced
`timescale 1ns/1ps

`include "althea_consts.svh"

module althea_assert (
	input logic clock,
	input logic reset125,
	input logic enable,
	input logic ack_valid,
	input logic playback_sync
);
	localparam int quiet_limit = `SYNC_STAGES + `ACK_DELAY + 2;

	int   low_cycles;    // consecutive cycles with enable low
	int   since_sync;    // cycles since the last sync pulse
	logic sync_seen;

	int ack_failures = 0;
	int sync_width_failures = 0;
	int sync_gap_failures = 0;

	always_ff @(posedge clock) begin
		if (reset125) begin
			low_cycles <= 0;
			since_sync <= 0;
			sync_seen  <= 1'b0;
		end else begin
			if (enable) low_cycles <= 0;
			else if (low_cycles < 1000) low_cycles <= low_cycles + 1;   // saturate

			if (playback_sync) begin
				since_sync <= 1;
				sync_seen  <= 1'b1;
			end else if (since_sync < 1000) begin
				since_sync <= since_sync + 1;
			end
		end
	end

	// ------------------------------
	ack_quiet: assert property (@(posedge clock) disable iff (reset125)
		low_cycles > quiet_limit |-> !ack_valid)
		else begin
			ack_failures++;
			$error("ack_valid high after enable low for %0d cycles", low_cycles);
		end

	sync_single: assert property (@(posedge clock) disable iff (reset125)
		playback_sync |=> !playback_sync)
		else begin
			sync_width_failures++;
			$error("playback_sync high on two cycles in a row");
		end

	// catches early pulses and missing pulses alike
	sync_spacing: assert property (@(posedge clock) disable iff (reset125)
		sync_seen |-> (playback_sync ? since_sync == `PLAYBACK_END
			: since_sync < `PLAYBACK_END))
		else begin
			sync_gap_failures++;
			$error("playback_sync spacing off, %0d cycles since last pulse", since_sync);
		end

endmodule

bind althea_top althea_assert u_assert (
	.clock(clock),
	.reset125(reset125),
	.enable(enable),
	.ack_valid(ack_valid),
	.playback_sync(playback_sync)
);

//--- src/althea_top.sv
// althea register core
// host bus sampler and protocol engine sharing a memory with the
// byte playback sequencer
`timescale 1ns/1ps

module althea_top
	import althea_pkg::*;
(
	input  logic         clock,
	input  logic         reset125,
	input  logic         enable,           // 1 active
	input  logic         read,             // 0 write, 1 read
	input  logic         register_select,  // 0 address, 1 data
	input  bus_byte_t    bus_in,
	output bus_byte_t    bus_out,
	output logic         bus_drive,
	output logic         ack_valid,
	output error_count_t error_count,
	output bus_byte_t    playback_byte,
	output logic         playback_sync
);
	logic       active;
	logic       idle;
	logic       read_level;
	logic       write_data_level;
	logic       write_addr_level;
	bus_byte_t  sampled_byte;
	word_addr_t word_addr;
	data_word_t write_word;
	logic       write_strobe;
	data_word_t read_word;
	byte_addr_t byte_addr;

	// host owns the bus except during reads
	assign bus_drive = read;

	bus_sampler u_sampler (
		.clock(clock), .reset125(reset125),
		.enable(enable), .read(read), .register_select(register_select), .bus_in(bus_in),
		.active(active), .idle(idle), .read_level(read_level),
		.write_data_level(write_data_level), .write_addr_level(write_addr_level),
		.sampled_byte(sampled_byte)
	);

	bus_protocol u_protocol (
		.clock(clock), .reset125(reset125),
		.active(active), .idle(idle), .read_level(read_level),
		.write_data_level(write_data_level), .write_addr_level(write_addr_level),
		.sampled_byte(sampled_byte), .read_word(read_word),
		.word_addr(word_addr), .write_word(write_word), .write_strobe(write_strobe),
		.bus_out(bus_out), .ack_valid(ack_valid), .error_count(error_count)
	);

	gearbox_ram u_ram (
		.clock(clock),
		.word_addr(word_addr), .write_word(write_word), .write_strobe(write_strobe),
		.byte_addr(byte_addr),
		.read_word(read_word), .playback_byte(playback_byte)
	);

	playback_sequencer u_playback (
		.clock(clock), .reset125(reset125),
		.byte_addr(byte_addr), .playback_sync(playback_sync)
	);

endmodule

//--- src/playback_sequencer.sv
// playback sequencer
// walks the memory byte by byte and wraps at the playback end,
// each wrap gives a delayed scope trigger
`timescale 1ns/1ps

`include "althea_consts.svh"

module playback_sequencer
	import althea_pkg::*;
(
	input  logic       clock,
	input  logic       reset125,
	output byte_addr_t byte_addr,
	output logic       playback_sync
);
	localparam byte_addr_t last_addr = byte_addr_t'(`PLAYBACK_END - 1);

	logic wrap_mark;   // high while byte_addr restarts at 0
	logic [`SYNC_DELAY-1:0] sync_pipe;

	always_ff @(posedge clock) begin
		if (reset125) begin
			byte_addr <= '0;
			wrap_mark <= 1'b0;
		end else if (byte_addr == last_addr) begin
			byte_addr <= '0;
			wrap_mark <= 1'b1;
		end else begin
			byte_addr <= byte_addr + 1'b1;
			wrap_mark <= 1'b0;
		end
	end

	// trigger lands while byte SYNC_DELAY-1 is on the output
	always_ff @(posedge clock) begin
		if (reset125) sync_pipe <= '0;
		else sync_pipe <= {sync_pipe[`SYNC_DELAY-2:0], wrap_mark};
	end

	assign playback_sync = sync_pipe[`SYNC_DELAY-1];

endmodule

//--- src/gearbox_ram.sv
// gearbox memory
// port A reads and writes whole data words for the host,
// port B reads single bytes for playback
`timescale 1ns/1ps

`include "althea_consts.svh"

module gearbox_ram
	import althea_pkg::*;
(
	input  logic       clock,
	input  word_addr_t word_addr,
	input  data_word_t write_word,
	input  logic       write_strobe,
	input  byte_addr_t byte_addr,
	output data_word_t read_word,
	output bus_byte_t  playback_byte
);
	localparam int lane_bits = $clog2(`DATA_BEATS);
	localparam int words     = 2 ** `ADDR_DEPTH;

	data_word_t mem [words];
	word_addr_t lane_word;
	logic [lane_bits-1:0] lane;

	// upper bits pick the word, low bits the lane
	assign lane_word = byte_addr[`ADDR_DEPTH+lane_bits-1:lane_bits];
	assign lane      = byte_addr[lane_bits-1:0];

	// ------------------------------
	// port A

	always_ff @(posedge clock) begin
		if (write_strobe) begin
			mem[word_addr] <= write_word;
		end
		read_word <= mem[word_addr];   // old data on a write cycle
	end

	// ------------------------------
	// port B

	// lane 0 is the least significant byte
	always_ff @(posedge clock) begin
		playback_byte <= mem[lane_word][lane*`BUS_WIDTH +: `BUS_WIDTH];
	end

endmodule

//--- src/bus_protocol.sv
// host bus protocol engine
// collects address and data beats into words, serves read bytes,
// auto-increments the word address and counts abandoned words
`timescale 1ns/1ps

`include "althea_consts.svh"

module bus_protocol
	import althea_pkg::*;
(
	input  logic         clock,
	input  logic         reset125,
	input  logic         active,
	input  logic         idle,
	input  logic         read_level,
	input  logic         write_data_level,
	input  logic         write_addr_level,
	input  bus_byte_t    sampled_byte,
	input  data_word_t   read_word,
	output word_addr_t   word_addr,
	output data_word_t   write_word,
	output logic         write_strobe,
	output bus_byte_t    bus_out,
	output logic         ack_valid,
	output error_count_t error_count
);
	localparam int addr_index_w = $clog2(`ADDR_BEATS);
	localparam int data_index_w = $clog2(`DATA_BEATS);
	localparam logic [addr_index_w-1:0] addr_first = addr_index_w'(`ADDR_BEATS - 1);
	localparam logic [data_index_w-1:0] data_first = data_index_w'(`DATA_BEATS - 1);

	beat_state_t addr_state;
	beat_state_t write_state;
	beat_state_t read_state;
	logic [addr_index_w-1:0] addr_index;   // counts down, msb first
	logic [data_index_w-1:0] write_index;
	logic [data_index_w-1:0] read_index;
	logic [`ADDR_BEATS*`BUS_WIDTH-1:0] addr_bytes;
	logic take_addr;
	logic take_write;
	logic take_read;
	logic addr_busy;
	logic write_busy;
	logic read_busy;
	logic drop_addr;
	logic drop_write;
	logic drop_read;
	logic [1:0] drop_count;
	logic ack_now;
	logic [`ACK_DELAY-1:0] ack_pipe;

	// ------------------------------
	// beat decode

	assign take_addr  = active && write_addr_level && addr_state == beat_idle;
	assign take_write = active && write_data_level && write_state == beat_idle;
	assign take_read  = active && read_level && read_state == beat_idle;

	assign addr_busy  = addr_state != beat_idle;
	assign write_busy = write_state != beat_idle;
	assign read_busy  = read_state != beat_idle;

	// partial word left behind while another kind of beat runs
	assign drop_addr  = !addr_busy && addr_index != addr_first && (write_busy || read_busy);
	assign drop_write = !write_busy && write_index != data_first && (addr_busy || read_busy);
	assign drop_read  = !read_busy && read_index != data_first && (addr_busy || write_busy);
	assign drop_count = 2'(drop_addr) + 2'(drop_write) + 2'(drop_read);

	// ------------------------------
	// collectors

	always_ff @(posedge clock) begin
		if (reset125) begin
			addr_state   <= beat_idle;
			write_state  <= beat_idle;
			read_state   <= beat_idle;
			addr_index   <= addr_first;
			write_index  <= data_first;
			read_index   <= data_first;
			word_addr    <= '0;
			write_strobe <= 1'b0;
			bus_out      <= '0;
			error_count  <= '0;
		end else begin
			write_strobe <= 1'b0;
			if (active) begin
				if (take_addr) addr_state <= beat_taken;
				if (take_write) write_state <= beat_taken;
				if (take_read) begin
					read_state <= beat_taken;
					bus_out    <= read_word[read_index*`BUS_WIDTH +: `BUS_WIDTH];
				end
			end else if (idle) begin
				error_count <= error_count + error_count_t'(drop_count);

				if (drop_addr || addr_state == beat_complete) begin
					addr_state <= beat_idle;
					addr_index <= addr_first;
				end else if (addr_state == beat_taken) begin
					if (addr_index == '0) addr_state <= beat_complete;
					else begin
						addr_state <= beat_idle;
						addr_index <= addr_index - 1'b1;
					end
				end

				if (drop_write || write_state == beat_complete) begin
					write_state <= beat_idle;
					write_index <= data_first;
				end else if (write_state == beat_taken) begin
					if (write_index == '0) begin
						write_state  <= beat_complete;
						write_strobe <= 1'b1;   // still at the old address
					end else begin
						write_state <= beat_idle;
						write_index <= write_index - 1'b1;
					end
				end

				if (drop_read || read_state == beat_complete) begin
					read_state <= beat_idle;
					read_index <= data_first;
				end else if (read_state == beat_taken) begin
					if (read_index == '0) read_state <= beat_complete;
					else begin
						read_state <= beat_idle;
						read_index <= read_index - 1'b1;
					end
				end

				// address load wins over the auto-increment
				if (addr_state == beat_complete) begin
					word_addr <= addr_bytes[`ADDR_DEPTH-1:0];
				end else if (write_state == beat_complete || read_state == beat_complete) begin
					word_addr <= word_addr + 1'b1;
				end
			end
		end
	end

	// byte lanes of the words being assembled
	always_ff @(posedge clock) begin
		if (take_addr) addr_bytes[addr_index*`BUS_WIDTH +: `BUS_WIDTH] <= sampled_byte;
		if (take_write) write_word[write_index*`BUS_WIDTH +: `BUS_WIDTH] <= sampled_byte;
	end

	// ------------------------------
	// acknowledge delay line

	assign ack_now = active && (read_level || write_data_level || write_addr_level);

	always_ff @(posedge clock) begin
		if (reset125) ack_pipe <= '0;
		else ack_pipe <= {ack_pipe[`ACK_DELAY-2:0], ack_now};
	end

	assign ack_valid = ack_pipe[`ACK_DELAY-1];

endmodule

//--- src/bus_sampler.sv
// host bus sampler
// shifts the strobes and the bus through a short pipeline and decodes
// levels only where the two oldest samples agree
`timescale 1ns/1ps

`include "althea_consts.svh"

module bus_sampler
	import althea_pkg::*;
(
	input  logic      clock,
	input  logic      reset125,
	input  logic      enable,
	input  logic      read,
	input  logic      register_select,
	input  bus_byte_t bus_in,
	output logic      active,
	output logic      idle,
	output logic      read_level,
	output logic      write_data_level,
	output logic      write_addr_level,
	output bus_byte_t sampled_byte
);
	localparam int oldest = `SYNC_STAGES - 1;

	logic [`SYNC_STAGES-1:0] enable_pipe;
	logic [`SYNC_STAGES-1:0] read_pipe;
	logic [`SYNC_STAGES-1:0] select_pipe;
	bus_byte_t bus_pipe [`SYNC_STAGES];
	logic [1:0] enable_old;
	logic [1:0] read_old;
	logic [1:0] select_old;

	always_ff @(posedge clock) begin
		if (reset125) begin
			enable_pipe <= '0;
			read_pipe   <= '0;
			select_pipe <= '0;
		end else begin
			enable_pipe <= {enable_pipe[oldest-1:0], enable};
			read_pipe   <= {read_pipe[oldest-1:0], read};
			select_pipe <= {select_pipe[oldest-1:0], register_select};
		end
	end

	// data bytes ride alongside the strobes
	always_ff @(posedge clock) begin
		bus_pipe[0] <= bus_in;
		for (int i = 1; i < `SYNC_STAGES; i++) begin
			bus_pipe[i] <= bus_pipe[i-1];
		end
	end

	assign enable_old = enable_pipe[oldest -: 2];
	assign read_old   = read_pipe[oldest -: 2];
	assign select_old = select_pipe[oldest -: 2];

	// a single-cycle glitch never gives two equal samples
	assign active           = enable_old == 2'b11;
	assign idle             = enable_old == 2'b00;
	assign read_level       = read_old == 2'b11;
	assign write_data_level = read_old == 2'b00 && select_old == 2'b11;
	assign write_addr_level = read_old == 2'b00 && select_old == 2'b00;
	assign sampled_byte     = bus_pipe[oldest];

endmodule

//--- src/althea_pkg.sv
// althea register core types
// vector widths with a meaning and the word collector state

`include "althea_consts.svh"

package althea_pkg;

	typedef logic [`BUS_WIDTH-1:0] bus_byte_t;
	typedef logic [`ADDR_DEPTH-1:0] word_addr_t;
	typedef logic [`DATA_BEATS*`BUS_WIDTH-1:0] data_word_t;

	// word address plus byte lane
	typedef logic [`ADDR_DEPTH+$clog2(`DATA_BEATS)-1:0] byte_addr_t;

	typedef logic [15:0] error_count_t;

	// one per collector (address, write, read)
	typedef enum logic [1:0] {
		beat_idle,      // waiting for an active phase
		beat_taken,     // byte handled this beat
		beat_complete   // last beat done, word finishing
	} beat_state_t;

endpackage

//--- src/althea_consts.svh
// althea register core constants
// bus geometry, beat counts, pipeline depths and the playback range
`ifndef ALTHEA_CONSTS_SVH
`define ALTHEA_CONSTS_SVH

// ------------------------------
// host bus
`define BUS_WIDTH    8    // parallel host bus
`define ADDR_BEATS   2    // bytes per address word
`define DATA_BEATS   4    // bytes per data word

// ------------------------------
// memory
`define ADDR_DEPTH   14   // word address bits

// ------------------------------
// pipelines
`define SYNC_STAGES  3    // input sampling depth
`define ACK_DELAY    4    // internal ack to ack_valid

// ------------------------------
// playback
`define PLAYBACK_END 64   // wrap point in bytes
`define SYNC_DELAY   3    // wrap to scope trigger

`endif
